/* files.f */
cpuPkg.sv
idExeIf.sv
regFile.sv
instrDecoder.sv
idExeReg.sv
execUnit.sv
issueCtrl.sv
mipsExeSlice.sv
tbMipsExeSlice.sv

/* run.sh */
#!/bin/sh
# build and run the slice testbench with Verilator

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module tbMipsExeSlice -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VtbMipsExeSlice > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

/* tbMipsExeSlice.sv */
`timescale 1ns/1ps

module tbMipsExeSlice;
    import cpuPkg::*;

    typedef struct packed {
        word_t    word;
        word_t    pc;
        logic     expValid;  // 0 for a squashed entry
        regAddr_t expDest;
        word_t    expData;
        logic     expBr;
    } entry_t;

    logic     clk;
    logic     rst;
    logic     instrReq;
    word_t    instrWord;
    word_t    instrPc;
    logic     instrAck;
    logic     resValid;
    word_t    resPc;
    regAddr_t resDest;
    word_t    resData;
    logic     brTaken;

    entry_t stimTable[$];
    integer seed;
    word_t  buildPc;
    int     errCount;
    int     unexpCount;
    int     pulseCount;
    int     curIdx;
    int     cycleCount = 0;
    logic   lastAck;
    logic   brSeen;

    mipsExeSlice i_mipsExeSlice (
        .clk       (clk),
        .rst       (rst),
        .instrReq  (instrReq),
        .instrWord (instrWord),
        .instrPc   (instrPc),
        .instrAck  (instrAck),
        .resValid  (resValid),
        .resPc     (resPc),
        .resDest   (resDest),
        .resData   (resData),
        .brTaken   (brTaken)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= 12 * stimTable.size() + 40) begin
            $display("timeout after %0d cycles, entry %0d did not complete", cycleCount, curIdx);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic word_t rTypeWord(regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                        shamt_t sa, logic [5:0] fn);
        return {OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t iTypeWord(logic [5:0] op, regAddr_t rs, regAddr_t rt,
                                        logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // appends one entry at the running pc
    task automatic addEntry(input word_t word, input logic expValid, input regAddr_t expDest,
                            input word_t expData, input logic expBr);
        entry_t e;
        begin
            e = {word, buildPc, expValid, expDest, expData, expBr};
            stimTable.push_back(e);
            buildPc = buildPc + 32'd4;
        end
    endtask

    task automatic reportMismatch(input string name, input word_t expV, input word_t gotV);
        begin
            errCount++;
            $display("error: time %0t %s expected %h got %h", $time, name, expV, gotV);
        end
    endtask

    task automatic checkResult;
        entry_t e;
        begin
            if (curIdx < 0 || !stimTable[curIdx].expValid) begin
                unexpCount++;
                $display("unexpected resValid at time %0t during entry %0d", $time, curIdx);
            end else begin
                e = stimTable[curIdx];
                pulseCount++;
                if (resDest !== e.expDest) reportMismatch("resDest", {27'd0, e.expDest},
                                                          {27'd0, resDest});
                if (resData !== e.expData) reportMismatch("resData", e.expData, resData);
                if (resPc !== e.pc) reportMismatch("resPc", e.pc, resPc);
                if (brSeen !== e.expBr) reportMismatch("brTaken", {31'd0, e.expBr},
                                                       {31'd0, brSeen});
                brSeen = 1'b0;
            end
        end
    endtask

    // advances one cycle and checks ack against the handshake rule at the falling edge
    task automatic stepCycle;
        logic reqHeld;
        logic ackExp;
        begin
            reqHeld = instrReq;  // value held over the rising edge
            @(negedge clk);
            ackExp = lastAck;
            if (!lastAck && reqHeld) ackExp = 1'b1;
            if (lastAck && !reqHeld) ackExp = 1'b0;
            if (instrAck !== ackExp) reportMismatch("instrAck", {31'd0, ackExp},
                                                    {31'd0, instrAck});
            lastAck = instrAck;
            if (brTaken === 1'b1) brSeen = 1'b1;
            if (resValid === 1'b1) checkResult();
        end
    endtask

    task automatic runEntry(input int idx);
        begin
            curIdx     = idx;
            pulseCount = 0;
            brSeen     = 1'b0;
            instrWord  = stimTable[idx].word;
            instrPc    = stimTable[idx].pc;
            instrReq   = 1'b1;
            stepCycle();
            while (instrAck !== 1'b1) stepCycle();
            instrReq = 1'b0;
            stepCycle();
            while (instrAck !== 1'b0) stepCycle();
            stepCycle();  // result window closes and the fsm returns to idle
            stepCycle();
            if (stimTable[idx].expValid && pulseCount != 1) begin
                errCount++;
                $display("entry %0d gave %0d result pulses instead of exactly one",
                         idx, pulseCount);
            end
        end
    endtask

    task automatic buildTable;
        word_t       rnd;
        logic [15:0] immHi;
        logic [15:0] immLo;
        logic [15:0] immC;
        word_t       r1;
        word_t       r2;
        word_t       r3;
        word_t       r11;
        word_t       brTgt;
        begin
            rnd   = $random(seed);
            immHi = rnd[15:0];
            rnd   = $random(seed);
            immLo = rnd[15:0];
            rnd   = $random(seed);
            immC  = rnd[15:0];
            buildPc = RESET_PC;
            r1  = {immHi, 16'h0000};
            addEntry(iTypeWord(OP_LUI, 5'd0, 5'd1, immHi), 1'b1, 5'd1, r1, 1'b0);
            r1  = r1 | {16'h0000, immLo};  // ori zero extends
            addEntry(iTypeWord(OP_ORI, 5'd1, 5'd1, immLo), 1'b1, 5'd1, r1, 1'b0);
            r2  = {{16{immC[15]}}, immC};
            addEntry(iTypeWord(OP_ADDIU, 5'd0, 5'd2, immC), 1'b1, 5'd2, r2, 1'b0);
            r3  = 32'hffff_fffb;  // -5
            addEntry(iTypeWord(OP_ADDIU, 5'd0, 5'd3, 16'hfffb), 1'b1, 5'd3, r3, 1'b0);
            r11 = 32'd7;
            addEntry(iTypeWord(OP_ADDIU, 5'd0, 5'd11, 16'd7), 1'b1, 5'd11, r11, 1'b0);
            addEntry(rTypeWord(5'd1, 5'd2, 5'd4, 5'd0, FN_ADDU), 1'b1, 5'd4, r1 + r2, 1'b0);
            addEntry(rTypeWord(5'd1, 5'd2, 5'd5, 5'd0, FN_SUBU), 1'b1, 5'd5, r1 - r2, 1'b0);
            addEntry(rTypeWord(5'd1, 5'd2, 5'd6, 5'd0, FN_AND), 1'b1, 5'd6, r1 & r2, 1'b0);
            addEntry(rTypeWord(5'd1, 5'd2, 5'd7, 5'd0, FN_OR), 1'b1, 5'd7, r1 | r2, 1'b0);
            addEntry(rTypeWord(5'd1, 5'd2, 5'd8, 5'd0, FN_XOR), 1'b1, 5'd8, r1 ^ r2, 1'b0);
            addEntry(rTypeWord(5'd3, 5'd2, 5'd9, 5'd0, FN_SLT), 1'b1, 5'd9,
                     ($signed(r3) < $signed(r2)) ? 32'd1 : 32'd0, 1'b0);
            addEntry(rTypeWord(5'd2, 5'd3, 5'd10, 5'd0, FN_SLT), 1'b1, 5'd10,
                     ($signed(r2) < $signed(r3)) ? 32'd1 : 32'd0, 1'b0);
            addEntry(rTypeWord(5'd3, 5'd11, 5'd12, 5'd0, FN_SLT), 1'b1, 5'd12, 32'd1, 1'b0);
            addEntry(rTypeWord(5'd11, 5'd3, 5'd13, 5'd0, FN_SLT), 1'b1, 5'd13, 32'd0, 1'b0);
            addEntry(rTypeWord(5'd0, 5'd1, 5'd14, 5'd4, FN_SLL), 1'b1, 5'd14, r1 << 4, 1'b0);
            addEntry(rTypeWord(5'd0, 5'd3, 5'd15, 5'd8, FN_SRL), 1'b1, 5'd15,
                     32'h00ff_ffff, 1'b0);
            // result is reported but r0 keeps zero
            addEntry(iTypeWord(OP_ADDIU, 5'd0, 5'd0, 16'h1234), 1'b1, 5'd0, 32'h1234, 1'b0);
            addEntry(rTypeWord(5'd0, 5'd11, 5'd16, 5'd0, FN_ADDU), 1'b1, 5'd16, r11, 1'b0);
            brTgt = buildPc + 32'd4 + 32'd12;
            addEntry(iTypeWord(OP_BEQ, 5'd11, 5'd11, 16'd3), 1'b1, 5'd0, brTgt, 1'b1);
            addEntry(iTypeWord(OP_ADDIU, 5'd0, 5'd17, 16'd99), 1'b0, 5'd0, 32'd0, 1'b0);
            buildPc = brTgt;  // r17 stays zero after the squash
            addEntry(rTypeWord(5'd17, 5'd11, 5'd18, 5'd0, FN_ADDU), 1'b1, 5'd18, r11, 1'b0);
            addEntry(iTypeWord(OP_BNE, 5'd11, 5'd11, 16'd5), 1'b1, 5'd0,
                     buildPc + 32'd4, 1'b0);
            addEntry(iTypeWord(OP_ADDIU, 5'd0, 5'd19, 16'd1), 1'b1, 5'd19, 32'd1, 1'b0);
        end
    endtask

    initial begin
        seed       = 32'hd07f3487;
        errCount   = 0;
        unexpCount = 0;
        pulseCount = 0;
        curIdx     = -1;
        lastAck    = 1'b0;
        brSeen     = 1'b0;
        rst        = 1'b0;
        instrReq   = 1'b0;
        instrWord  = '0;
        instrPc    = '0;
        buildTable();
        repeat (8) stepCycle();
        rst = 1'b1;
        repeat (4) stepCycle();  // ack and resValid must stay low while idle
        for (int i = 0; i < stimTable.size(); i++) begin
            runEntry(i);
        end
        $display("errors: %0d check failures, %0d unexpected resValid pulses",
                 errCount, unexpCount);
        if ((errCount == 0) && (unexpCount == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* mipsExeSlice.sv */
`timescale 1ns/1ps

module mipsExeSlice (
    input  logic             clk,
    input  logic             rst,
    input  logic             instrReq,
    input  cpuPkg::word_t    instrWord,
    input  cpuPkg::word_t    instrPc,
    output logic             instrAck,
    output logic             resValid,
    output cpuPkg::word_t    resPc,
    output cpuPkg::regAddr_t resDest,
    output cpuPkg::word_t    resData,
    output logic             brTaken
);
    import cpuPkg::*;

    regAddr_t rdAddrA;
    regAddr_t rdAddrB;
    word_t    rdDataA;
    word_t    rdDataB;
    logic     wrEn;
    regAddr_t wrAddr;
    word_t    wrData;
    logic     wr;
    logic     flush;
    word_t    brTarget;

    idExeIf decIf ();  // decoder to pipeline register
    idExeIf exeIf ();  // pipeline register to execute

    regFile i_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    instrDecoder i_instrDecoder (
        .instrWord (instrWord),
        .instrPc   (instrPc),
        .rdAddrA   (rdAddrA),
        .rdAddrB   (rdAddrB),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .decOut    (decIf.src)
    );

    idExeReg i_idExeReg (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr),
        .flush (flush),
        .dIn   (decIf.dst),
        .qOut  (exeIf.src)
    );

    execUnit i_execUnit (
        .clk      (clk),
        .rst      (rst),
        .exIn     (exeIf.dst),
        .brTaken  (brTaken),
        .brTarget (brTarget),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .resValid (resValid),
        .resDest  (resDest),
        .resPc    (resPc),
        .resData  (resData)
    );

    issueCtrl i_issueCtrl (
        .clk      (clk),
        .rst      (rst),
        .instrReq (instrReq),
        .instrAck (instrAck),
        .instrPc  (instrPc),
        .brTaken  (brTaken),
        .brTarget (brTarget),
        .exeValid (exeIf.valid),
        .wr       (wr),
        .flush    (flush)
    );

endmodule

/* issueCtrl.sv */
`timescale 1ns/1ps

module issueCtrl (
    input  logic          clk,
    input  logic          rst,
    input  logic          instrReq,
    output logic          instrAck,
    input  cpuPkg::word_t instrPc,
    input  logic          brTaken,
    input  cpuPkg::word_t brTarget,
    input  logic          exeValid,
    output logic          wr,
    output logic          flush
);
    import cpuPkg::*;

    issueState_t state;
    issueState_t stateNext;
    word_t       expPc;     // pc the next instruction should carry
    word_t       acceptPc;  // pc of the instruction now in exe
    logic        squash;
    logic        accept;

    assign accept   = (state == IDLE) && instrReq;
    assign wr       = accept;
    assign flush    = accept && squash && (instrPc != expPc);
    assign instrAck = (state == BUSY);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE:    if (instrReq) stateNext = BUSY;
            BUSY:    if (!instrReq) stateNext = RELEASE;
            RELEASE: stateNext = IDLE;  // ack is already low here
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // branch outcome is valid while the instruction sits in exe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            expPc  <= RESET_PC;
            squash <= 1'b0;
        end else if (exeValid) begin
            expPc  <= brTaken ? brTarget : acceptPc + 32'd4;
            squash <= brTaken;
        end else if (accept) begin
            squash <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            acceptPc <= instrPc;
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rst)
        $rose(instrAck) |-> $past(instrReq))
        else $error("issueCtrl: ack rose without req");

endmodule

/* execUnit.sv */
`timescale 1ns/1ps

module execUnit (
    input  logic             clk,
    input  logic             rst,
    idExeIf.dst              exIn,
    output logic             brTaken,
    output cpuPkg::word_t    brTarget,
    output logic             wrEn,
    output cpuPkg::regAddr_t wrAddr,
    output cpuPkg::word_t    wrData,
    output logic             resValid,
    output cpuPkg::regAddr_t resDest,
    output cpuPkg::word_t    resPc,
    output cpuPkg::word_t    resData
);
    import cpuPkg::*;

    word_t opB;
    word_t aluRes;
    word_t pcPlus4;
    word_t nextPc;
    logic  isBranch;
    logic  opsEqual;
    logic  wbWrEn;

    assign opB = exIn.aluSrcB ? exIn.imm : exIn.busB;

    always_comb begin
        case (exIn.aluOp)
            ALU_ADD: aluRes = exIn.busA + opB;
            ALU_SUB: aluRes = exIn.busA - opB;
            ALU_AND: aluRes = exIn.busA & opB;
            ALU_OR:  aluRes = exIn.busA | opB;
            ALU_XOR: aluRes = exIn.busA ^ opB;
            ALU_SLT: aluRes = {31'd0, $signed(exIn.busA) < $signed(opB)};
            ALU_SLL: aluRes = exIn.busB << exIn.shamt;
            ALU_SRL: aluRes = exIn.busB >> exIn.shamt;  // logical
            ALU_LUI: aluRes = {exIn.imm[15:0], 16'h0000};
            default: aluRes = '0;
        endcase
    end

    assign isBranch = (exIn.brType != BR_NONE);
    assign opsEqual = (exIn.busA == exIn.busB);
    assign pcPlus4  = exIn.pc + 32'd4;
    assign brTarget = pcPlus4 + {exIn.imm[29:0], 2'b00};
    assign brTaken  = exIn.valid && (((exIn.brType == BR_BEQ) && opsEqual) ||
                                     ((exIn.brType == BR_BNE) && !opsEqual));
    assign nextPc   = brTaken ? brTarget : pcPlus4;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            resValid <= 1'b0;
            wbWrEn   <= 1'b0;
        end else begin
            resValid <= exIn.valid;
            wbWrEn   <= exIn.valid && exIn.regWr && (exIn.dest != '0);  // r0 never written
        end
    end

    // writeback payload
    always_ff @(posedge clk) begin
        if (exIn.valid) begin
            resPc   <= exIn.pc;
            resDest <= isBranch ? '0 : exIn.dest;
            resData <= isBranch ? nextPc : aluRes;  // branches report the next pc
        end
    end

    assign wrEn   = wbWrEn;
    assign wrAddr = resDest;
    assign wrData = resData;

    noZeroWrite: assert property (@(posedge clk) disable iff (!rst) wrEn |-> (wrAddr != '0))
        else $error("execUnit: write to register 0");

endmodule

/* idExeReg.sv */
`timescale 1ns/1ps

module idExeReg (
    input  logic clk,
    input  logic rst,
    input  logic wr,
    input  logic flush,
    idExeIf.dst  dIn,
    idExeIf.src  qOut
);
    import cpuPkg::*;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            qOut.valid   <= 1'b0;
            qOut.pc      <= '0;
            qOut.busA    <= '0;
            qOut.busB    <= '0;
            qOut.imm     <= '0;
            qOut.shamt   <= '0;
            qOut.dest    <= '0;
            qOut.regWr   <= 1'b0;
            qOut.aluOp   <= ALU_PASS_NONE;
            qOut.aluSrcB <= 1'b0;
            qOut.brType  <= BR_NONE;
        end else if (flush) begin  // squashed accept becomes a bubble
            qOut.valid   <= 1'b0;
            qOut.pc      <= '0;
            qOut.busA    <= '0;
            qOut.busB    <= '0;
            qOut.imm     <= '0;
            qOut.shamt   <= '0;
            qOut.dest    <= '0;
            qOut.regWr   <= 1'b0;
            qOut.aluOp   <= ALU_PASS_NONE;
            qOut.aluSrcB <= 1'b0;
            qOut.brType  <= BR_NONE;
        end else if (wr) begin
            qOut.valid   <= dIn.valid;
            qOut.pc      <= dIn.pc;
            qOut.busA    <= dIn.busA;
            qOut.busB    <= dIn.busB;
            qOut.imm     <= dIn.imm;
            qOut.shamt   <= dIn.shamt;
            qOut.dest    <= dIn.dest;
            qOut.regWr   <= dIn.regWr;
            qOut.aluOp   <= dIn.aluOp;
            qOut.aluSrcB <= dIn.aluSrcB;
            qOut.brType  <= dIn.brType;
        end else begin
            qOut.valid   <= 1'b0;  // one cycle in exe per instruction
        end
    end

    // issue control only squashes on an accept
    flushNeedsWr: assert property (@(posedge clk) disable iff (!rst) flush |-> wr)
        else $error("idExeReg: flush without wr");

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  cpuPkg::word_t    instrWord,
    input  cpuPkg::word_t    instrPc,
    output cpuPkg::regAddr_t rdAddrA,
    output cpuPkg::regAddr_t rdAddrB,
    input  cpuPkg::word_t    rdDataA,
    input  cpuPkg::word_t    rdDataB,
    idExeIf.src              decOut
);
    import cpuPkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    regAddr_t    rs;
    regAddr_t    rt;
    regAddr_t    rd;
    logic [15:0] imm16;

    assign opcode = instrWord[31:26];
    assign rs     = instrWord[25:21];
    assign rt     = instrWord[20:16];
    assign rd     = instrWord[15:11];
    assign funct  = instrWord[5:0];
    assign imm16  = instrWord[15:0];

    assign rdAddrA = rs;
    assign rdAddrB = rt;

    assign decOut.valid = 1'b1;  // squash only shows up as a flush
    assign decOut.pc    = instrPc;
    assign decOut.busA  = rdDataA;
    assign decOut.busB  = rdDataB;
    assign decOut.shamt = instrWord[10:6];

    always_comb begin
        decOut.dest    = '0;
        decOut.regWr   = 1'b0;
        decOut.aluOp   = ALU_PASS_NONE;
        decOut.aluSrcB = 1'b0;
        decOut.brType  = BR_NONE;
        decOut.imm     = {{16{imm16[15]}}, imm16};  // sign extend by default
        case (opcode)
            OP_RTYPE: begin
                decOut.dest  = rd;
                decOut.regWr = 1'b1;
                case (funct)
                    FN_ADDU: decOut.aluOp = ALU_ADD;
                    FN_SUBU: decOut.aluOp = ALU_SUB;
                    FN_AND:  decOut.aluOp = ALU_AND;
                    FN_OR:   decOut.aluOp = ALU_OR;
                    FN_XOR:  decOut.aluOp = ALU_XOR;
                    FN_SLT:  decOut.aluOp = ALU_SLT;
                    FN_SLL:  decOut.aluOp = ALU_SLL;
                    FN_SRL:  decOut.aluOp = ALU_SRL;
                    default: begin  // unsupported funct acts as a nop
                        decOut.dest  = '0;
                        decOut.regWr = 1'b0;
                    end
                endcase
            end
            OP_ADDIU: begin
                decOut.dest    = rt;
                decOut.regWr   = 1'b1;
                decOut.aluOp   = ALU_ADD;
                decOut.aluSrcB = 1'b1;
            end
            OP_ORI: begin
                decOut.dest    = rt;
                decOut.regWr   = 1'b1;
                decOut.aluOp   = ALU_OR;
                decOut.aluSrcB = 1'b1;
                decOut.imm     = {16'h0000, imm16};  // zero extend for the logical op
            end
            OP_LUI: begin
                decOut.dest    = rt;
                decOut.regWr   = 1'b1;
                decOut.aluOp   = ALU_LUI;
                decOut.aluSrcB = 1'b1;
            end
            OP_BEQ:  decOut.brType = BR_BEQ;
            OP_BNE:  decOut.brType = BR_BNE;
            default: ;  // unknown opcode keeps the nop defaults
        endcase
    end

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::regAddr_t rdAddrA,
    input  cpuPkg::regAddr_t rdAddrB,
    output cpuPkg::word_t    rdDataA,
    output cpuPkg::word_t    rdDataB,
    input  logic             wrEn,
    input  cpuPkg::regAddr_t wrAddr,
    input  cpuPkg::word_t    wrData
);
    import cpuPkg::*;

    word_t regs [32];

    // entry 0 is cleared by reset and never written, so it reads zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];  // async read
    assign rdDataB = regs[rdAddrB];

endmodule

/* idExeIf.sv */
`timescale 1ns/1ps

interface idExeIf;
    import cpuPkg::*;

    logic     valid;
    word_t    pc;
    word_t    busA;     // rs operand
    word_t    busB;     // rt operand
    word_t    imm;      // extended immediate
    shamt_t   shamt;
    regAddr_t dest;     // 0 when nothing is written
    logic     regWr;
    aluOp_t   aluOp;
    logic     aluSrcB;  // 1 picks imm as operand b
    brType_t  brType;

    modport src (
        output valid, pc, busA, busB, imm, shamt, dest, regWr, aluOp, aluSrcB, brType
    );

    modport dst (
        input valid, pc, busA, busB, imm, shamt, dest, regWr, aluOp, aluSrcB, brType
    );

endinterface

/* cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] word_t;     // data, pc or instruction word
    typedef logic [4:0]  regAddr_t;  // register index
    typedef logic [4:0]  shamt_t;    // shift amount

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_PASS_NONE  // no result for bubbles and unknown ops
    } aluOp_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE
    } brType_t;

    typedef enum logic [1:0] {
        IDLE,     // waiting for req
        BUSY,     // ack high while req stays up
        RELEASE   // ack low again for one cycle before the next accept
    } issueState_t;

    // primary opcodes in instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    // R-type function codes in instr[5:0]
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;

    localparam word_t RESET_PC = 32'h0000_0000;  // first expected fetch address

endpackage
